// File: lsu.f
hdl/lsu_pkg.sv
hdl/lsu_address.sv
hdl/lsu_request.sv
hdl/lsu_data_ram.sv
hdl/lsu_io_regs.sv
hdl/lsu_response.sv
hdl/lsu_top.sv
verif/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - hdl/lsu_pkg.sv
  - hdl/lsu_address.sv
  - hdl/lsu_request.sv
  - hdl/lsu_data_ram.sv
  - hdl/lsu_io_regs.sv
  - hdl/lsu_response.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - verif/lsu_tb.sv

// File: verif/lsu_stimulus.txt
# name op rs1 rs2 imm rd req_stall resp_stall flush chain expect trap trap_address
# rs2 rand takes a random word, expect model takes the load value from the shadow
fill_w0      sw  00001000 rand     00000000  0 0 0 0 0 00000000 0 00000000
fill_w1      sw  00001000 rand     00000004  0 0 0 0 1 00000000 0 00000000
load_b1      lb  00001000 0        00000001  5 0 0 0 1 model    0 00000000
load_hu6     lhu 00001004 0        00000002  6 0 0 0 1 model    0 00000000
store_b0     sb  00001010 00000081 00000000  0 0 0 0 0 00000000 0 00000000
store_b1     sb  00001010 00000002 00000001  0 0 0 0 1 00000000 0 00000000
store_b2     sb  00001010 000000f3 00000002  0 0 0 0 1 00000000 0 00000000
store_b3     sb  00001010 00000044 00000003  0 0 0 0 1 00000000 0 00000000
load_w_bytes lw  00001010 0        00000000  7 0 0 0 0 44f30281 0 00000000
load_b_sign  lb  00001010 0        00000002  8 0 0 0 1 fffffff3 0 00000000
store_h0     sh  00001014 00008001 00000000  0 0 0 0 0 00000000 0 00000000
store_h2     sh  00001014 12347ffe 00000002  0 0 0 0 1 00000000 0 00000000
load_h_sign  lh  00001014 0        00000000  9 0 0 0 0 ffff8001 0 00000000
load_hu_hi   lhu 00001014 0        00000002 10 0 0 0 1 00007ffe 0 00000000
io_store_w1  sw  00002004 cafebabe 00000000  0 0 0 0 0 00000000 0 00000000
io_alias_w   lw  00002100 0        00000004 11 0 0 0 1 cafebabe 0 00000000
io_alias_bu  lbu 00002010 0        00000007 12 0 0 0 1 000000ca 0 00000000
trap_sw      sw  00001000 ffffffff 00000012  0 0 0 0 0 00000000 1 00001012
trap_lh      lh  00001000 0        00000011 13 0 0 0 1 00000000 1 00001011
after_trap   lw  00001010 0        00000000 14 0 0 0 1 model    0 00000000
stall_req    lw  00001000 0        00000000 15 2 0 0 0 model    0 00000000
stall_resp   sb  00001000 0000005a 00000003  0 0 3 0 0 00000000 0 00000000
stall_both   lw  00001000 0        00000000 16 1 2 0 0 model    0 00000000
flush_sw     sw  00001010 00000000 00000000  0 0 0 1 0 00000000 0 00000000
after_flush  lw  00001010 0        00000000 17 0 0 0 0 model    0 00000000
b2b_sw       sw  00001020 9abc8765 00000000  0 0 0 0 0 00000000 0 00000000
b2b_lw       lw  00001024 0        fffffffc 18 0 0 0 1 model    0 00000000
b2b_lh       lh  00001020 0        00000002 19 0 0 0 1 model    0 00000000
b2b_lbu      lbu 00001020 0        00000001 20 0 0 0 1 model    0 00000000
b2b_sb       sb  00001020 00000011 00000003  0 0 0 0 1 00000000 0 00000000
b2b_lw_last  lw  00001020 0        00000000 21 0 0 0 1 model    0 00000000

// File: verif/lsu_tb.sv
module lsu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import lsu_pkg::*;

  logic        clk_core;
  logic        reset_i;
  mem_data_t   op_i;
  logic        valid_i;
  logic        request_stall_i;
  logic        response_stall_i;
  logic        flush_i;
  lsu_result_t result_o;
  logic        result_valid_o;

  // One entry per stimulus line, all queues share the same index
  string     names[$];
  mem_data_t ops[$];
  int        req_stalls[$];
  int        resp_stalls[$];
  logic      flushes[$];
  logic      chains[$];
  logic      use_model[$];
  word_t     exp_value[$];
  logic      exp_trap[$];
  word_t     exp_trap_address[$];

  // Byte image of both targets, keyed by the canonical byte address
  logic [7:0] shadow [word_t];

  // Instructions in flight and the cycle in which each result is due
  int pend_idx[$];
  int pend_cycle[$];

  int cycle = 0;
  int cycle_limit = 32'h7fff_ffff;
  int pass_count = 0;
  int fail_count = 0;
  int stray_count = 0;

  lsu_top dut_i (
    .clk_core,
    .reset_i,
    .op_i,
    .valid_i,
    .request_stall_i,
    .response_stall_i,
    .flush_i,
    .result_o,
    .result_valid_o
  );

  initial clk_core = 1'b0;
  always #2 clk_core = ~clk_core;

  always @(posedge clk_core) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("Timeout after %0d cycles, results are still outstanding", cycle);
      $display("Simulation failed");
      $finish;
    end
  end

  // RAM bytes keep their address, the I/O region folds onto 16 bytes
  function automatic word_t canonical(word_t a);
    if (a >= MemBase && a < MemBase + MemWords * 4) begin
      return a;
    end
    return IoBase + ((a - IoBase) & 32'h0000_000f);
  endfunction

  function automatic int size_bytes(mem_size_e s);
    case (s)
      MEM_SIZE_BYTE: return 1;
      MEM_SIZE_HALF: return 2;
      default:       return 4;
    endcase
  endfunction

  // Little endian gather from the shadow, sign fill only for MEM_OP_LOAD
  function automatic word_t model_load(word_t a, mem_op_e op, mem_size_e s);
    word_t v;
    int    n;
    v = '0;
    n = size_bytes(s);
    for (int i = 0; i < n; i++) begin
      if (shadow.exists(canonical(a + i))) begin
        v[8*i +: 8] = shadow[canonical(a + i)];
      end else begin
        v[8*i +: 8] = 'x;
      end
    end
    if (op == MEM_OP_LOAD && n < 4 && v[8*n-1]) begin
      v = v | (32'hffff_ffff << (8 * n));
    end
    return v;
  endfunction

  // Narrow stores always take the low bytes of rs2
  function automatic void model_store(word_t a, mem_size_e s, word_t data);
    for (int i = 0; i < size_bytes(s); i++) begin
      shadow[canonical(a + i)] = data[8*i +: 8];
    end
  endfunction

  task automatic read_stimulus();
    int        fd;
    int        n;
    int        rd;
    int        rq;
    int        rp;
    int        fl;
    int        ch;
    int        tr;
    string     line;
    string     name;
    string     mnem;
    string     rs2_s;
    string     exp_s;
    word_t     rs1;
    word_t     rs2;
    word_t     imm;
    word_t     val;
    word_t     tadr;
    mem_data_t op;
    fd = $fopen("verif/lsu_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file verif/lsu_stimulus.txt");
      fail_count++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) == 0) begin
          break;
        end
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %s %h %s %h %d %d %d %d %d %s %d %h", name, mnem, rs1,
                    rs2_s, imm, rd, rq, rp, fl, ch, exp_s, tr, tadr);
        if (n != 13) begin
          $display("Stimulus line could not be parsed: %s", line);
          fail_count++;
          continue;
        end
        // Mnemonics follow RISC-V, an s prefix is a store and a u suffix unsigned
        if (mnem[0] == "s") begin
          op.op = MEM_OP_STORE;
        end else if (mnem.len() == 3) begin
          op.op = MEM_OP_LOAD_UNSIGNED;
        end else begin
          op.op = MEM_OP_LOAD;
        end
        case (mnem.substr(1, 1))
          "b":     op.size = MEM_SIZE_BYTE;
          "h":     op.size = MEM_SIZE_HALF;
          default: op.size = MEM_SIZE_WORD;
        endcase
        if (rs2_s == "rand") begin
          rs2 = $urandom();
        end else begin
          void'($sscanf(rs2_s, "%h", rs2));
        end
        val = '0;
        if (exp_s != "model") begin
          void'($sscanf(exp_s, "%h", val));
        end
        op.rs1 = rs1;
        op.rs2 = rs2;
        op.immediate = imm;
        op.rd = reg_index_t'(rd);
        names.push_back(name);
        ops.push_back(op);
        req_stalls.push_back(rq);
        resp_stalls.push_back(rp);
        flushes.push_back(fl != 0);
        chains.push_back(ch != 0);
        use_model.push_back(exp_s == "model");
        exp_value.push_back(val);
        exp_trap.push_back(tr != 0);
        exp_trap_address.push_back(tadr);
      end
      $fclose(fd);
    end
  endtask

  task automatic report_mismatch(string test, string field, word_t exp, word_t act,
                                 inout int errs);
    $display("Error: %s %s expected %h actual %h", test, field, exp, act);
    errs++;
  endtask

  task automatic check_result(int idx, int due);
    int        errs;
    mem_data_t op;
    logic      is_load;
    errs = 0;
    op = ops[idx];
    // A trap never counts as a load, whatever the op was
    is_load = (op.op != MEM_OP_STORE) && !exp_trap[idx];
    if (cycle != due) begin
      report_mismatch(names[idx], "cycle", due, cycle, errs);
    end
    if (result_o.rd_value !== exp_value[idx]) begin
      report_mismatch(names[idx], "rd_value", exp_value[idx], result_o.rd_value, errs);
    end
    if (result_o.trap !== exp_trap[idx]) begin
      report_mismatch(names[idx], "trap", exp_trap[idx], result_o.trap, errs);
    end
    if (result_o.trap_address !== exp_trap_address[idx]) begin
      report_mismatch(names[idx], "trap_address", exp_trap_address[idx],
                      result_o.trap_address, errs);
    end
    if (result_o.is_load !== is_load) begin
      report_mismatch(names[idx], "is_load", is_load, result_o.is_load, errs);
    end
    if (result_o.rd !== op.rd) begin
      report_mismatch(names[idx], "rd", op.rd, result_o.rd, errs);
    end
    if (errs == 0) begin
      $display("PASS  %s", names[idx]);
      pass_count++;
    end else begin
      $display("FAIL  %s", names[idx]);
      fail_count++;
    end
  endtask

  // Outputs are sampled at the falling edge, half a period after they settle
  always @(negedge clk_core) begin
    if (!reset_i) begin
      if (result_valid_o === 1'b1) begin
        if (pend_idx.size() == 0) begin
          $display("Unexpected result for rd %0d in cycle %0d with nothing in flight",
                   result_o.rd, cycle);
          stray_count++;
        end else begin
          check_result(pend_idx.pop_front(), pend_cycle.pop_front());
        end
      end else if (pend_idx.size() != 0 && cycle >= pend_cycle[0]) begin
        $display("FAIL  %s: no result by cycle %0d", names[pend_idx[0]], cycle);
        fail_count++;
        void'(pend_idx.pop_front());
        void'(pend_cycle.pop_front());
      end
    end
  end

  task automatic drive_idle();
    op_i = '0;
    valid_i = 1'b0;
    request_stall_i = 1'b0;
    response_stall_i = 1'b0;
    flush_i = 1'b0;
  endtask

  task automatic drain();
    while (pend_idx.size() != 0) begin
      @(negedge clk_core);
    end
  endtask

  task automatic issue(int idx);
    mem_data_t op;
    word_t     addr;
    int        stall_cycles;
    int        strays;
    op = ops[idx];
    addr = op.rs1 + op.immediate;
    stall_cycles = (req_stalls[idx] > resp_stalls[idx]) ? req_stalls[idx] : resp_stalls[idx];
    // The instruction sits on valid_i under back-pressure and must not enter
    for (int i = 0; i < stall_cycles; i++) begin
      @(posedge clk_core);
      #1;
      op_i = op;
      valid_i = 1'b1;
      request_stall_i = i < req_stalls[idx];
      response_stall_i = i < resp_stalls[idx];
    end
    @(posedge clk_core);
    #1;
    op_i = op;
    valid_i = 1'b1;
    request_stall_i = 1'b0;
    response_stall_i = 1'b0;
    if (use_model[idx] && op.op != MEM_OP_STORE) begin
      exp_value[idx] = model_load(addr, op.op, op.size);
    end
    if (flushes[idx]) begin
      // Flush lands in the cycle after acceptance, so no result may follow
      strays = stray_count;
      @(posedge clk_core);
      #1;
      valid_i = 1'b0;
      flush_i = 1'b1;
      @(posedge clk_core);
      #1;
      flush_i = 1'b0;
      repeat (3) @(posedge clk_core);
      if (stray_count != strays) begin
        $display("FAIL  %s: flushed instruction still produced a result", names[idx]);
        fail_count++;
      end else begin
        $display("PASS  %s", names[idx]);
        pass_count++;
      end
    end else begin
      pend_idx.push_back(idx);
      pend_cycle.push_back(cycle + 2);
      if (op.op == MEM_OP_STORE && !exp_trap[idx]) begin
        model_store(addr, op.size, op.rs2);
      end
    end
  endtask

  initial begin
    void'($urandom(32'hc953_cb03));
    drive_idle();
    reset_i = 1'b1;
    read_stimulus();
    cycle_limit = 8 * names.size() + 100;
    repeat (4) @(posedge clk_core);
    #1;
    reset_i = 1'b0;
    // Chained lines go out on consecutive cycles, others start on an empty pipe
    for (int i = 0; i < names.size(); i++) begin
      if (!chains[i]) begin
        @(posedge clk_core);
        #1;
        drive_idle();
        drain();
      end
      issue(i);
    end
    @(posedge clk_core);
    #1;
    drive_idle();
    drain();
    repeat (2) @(posedge clk_core);
    $display("Tests passed: %0d, failed: %0d, unexpected results: %0d",
             pass_count, fail_count, stray_count);
    if (fail_count == 0 && stray_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: hdl/lsu_top.sv
module lsu_top (
  input  logic                 clk_core,
  input  logic                 reset_i,
  input  lsu_pkg::mem_data_t   op_i,
  input  logic                 valid_i,
  input  logic                 request_stall_i,
  input  logic                 response_stall_i,
  input  logic                 flush_i,
  output lsu_pkg::lsu_result_t result_o,
  output logic                 result_valid_o
);

  import lsu_pkg::*;

  read_write_t transaction;
  logic        request_valid;
  logic        response_valid;

  // Shared target port, the enables pick RAM or I/O
  logic    ram_en;
  logic    io_en;
  logic    we;
  index_t  index;
  word_t   wdata;
  strobe_t strobe;
  word_t   ram_rdata;
  word_t   io_rdata;

  lsu_address address_i (
    .clk_core,
    .reset_i,
    .flush_i,
    .request_stall_i,
    .response_stall_i,
    .op_i,
    .valid_i,
    .transaction_o   (transaction),
    .request_valid_o (request_valid),
    .response_valid_o(response_valid)
  );

  lsu_request request_i (
    .request_valid_i(request_valid),
    .transaction_i  (transaction),
    .ram_en_o       (ram_en),
    .io_en_o        (io_en),
    .we_o           (we),
    .index_o        (index),
    .wdata_o        (wdata),
    .strobe_o       (strobe)
  );

  lsu_data_ram data_ram_i (
    .clk_core,
    .en_i    (ram_en),
    .we_i    (we),
    .index_i (index),
    .wdata_i (wdata),
    .strobe_i(strobe),
    .rdata_o (ram_rdata)
  );

  lsu_io_regs io_regs_i (
    .clk_core,
    .en_i    (io_en),
    .we_i    (we),
    .index_i (index),
    .wdata_i (wdata),
    .strobe_i(strobe),
    .rdata_o (io_rdata)
  );

  lsu_response response_i (
    .clk_core,
    .reset_i,
    .flush_i,
    .response_valid_i(response_valid),
    .transaction_i   (transaction),
    .ram_rdata_i     (ram_rdata),
    .io_rdata_i      (io_rdata),
    .result_o,
    .result_valid_o
  );

endmodule

// File: hdl/lsu_response.sv
module lsu_response (
  input  logic                 clk_core,
  input  logic                 reset_i,
  input  logic                 flush_i,
  input  logic                 response_valid_i,
  input  lsu_pkg::read_write_t transaction_i,
  input  lsu_pkg::word_t       ram_rdata_i,
  input  lsu_pkg::word_t       io_rdata_i,
  output lsu_pkg::lsu_result_t result_o,
  output logic                 result_valid_o
);

  import lsu_pkg::*;

  read_write_t held_q;
  word_t       read_word;
  word_t       shifted;
  word_t       load_value;
  logic        sign_extend;

  // The transaction is held while the target performs its read, so it
  // lines up with the returned word one cycle later
  always_ff @(posedge clk_core) begin
    if (response_valid_i) begin
      held_q <= transaction_i;
    end
  end

  always_ff @(posedge clk_core) begin
    if (reset_i || flush_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= response_valid_i;
    end
  end

  always_comb begin
    // Both targets answer every cycle, is_memory says which one was used
    if (held_q.is_memory) begin
      read_word = ram_rdata_i;
    end else begin
      read_word = io_rdata_i;
    end

    // Move the addressed byte or half down to bit 0
    shifted = read_word >> {held_q.address[ByteOffsetBits-1:0], 3'b000};

    sign_extend = held_q.mem_data.op == MEM_OP_LOAD;

    case (held_q.mem_data.size)
      MEM_SIZE_BYTE: load_value = {{24{sign_extend & shifted[7]}}, shifted[7:0]};
      MEM_SIZE_HALF: load_value = {{16{sign_extend & shifted[15]}}, shifted[15:0]};
      default:       load_value = shifted;
    endcase
  end

  always_comb begin
    result_o.rd = held_q.mem_data.rd;
    result_o.rd_value = '0;
    result_o.is_load = 1'b0;
    result_o.trap = 1'b0;
    result_o.trap_address = '0;

    // A trap replaces the load result and carries the faulting address
    if (held_q.misaligned_address) begin
      result_o.trap = 1'b1;
      result_o.trap_address = held_q.address;
    end else if (held_q.mem_data.op != MEM_OP_STORE) begin
      result_o.is_load = 1'b1;
      result_o.rd_value = load_value;
    end
  end

endmodule

// File: hdl/lsu_io_regs.sv
module lsu_io_regs (
  input  logic             clk_core,
  input  logic             en_i,
  input  logic             we_i,
  input  lsu_pkg::index_t  index_i,
  input  lsu_pkg::word_t   wdata_i,
  input  lsu_pkg::strobe_t strobe_i,
  output lsu_pkg::word_t   rdata_o
);

  import lsu_pkg::*;

  word_t                scratch [IoRegs];
  logic [IoSelBits-1:0] sel;

  // Only the low index bits decode, so the rest of the I/O region
  // aliases onto the same four registers
  assign sel = index_i[IoSelBits-1:0];

  always_ff @(posedge clk_core) begin
    if (en_i && we_i) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (strobe_i[lane]) begin
          scratch[sel][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
        end
      end
    end
  end

  // Same one cycle read as the data RAM, old value on a write
  always_ff @(posedge clk_core) begin
    if (en_i) begin
      rdata_o <= scratch[sel];
    end
  end

endmodule

// File: hdl/lsu_data_ram.sv
module lsu_data_ram (
  input  logic             clk_core,
  input  logic             en_i,
  input  logic             we_i,
  input  lsu_pkg::index_t  index_i,
  input  lsu_pkg::word_t   wdata_i,
  input  lsu_pkg::strobe_t strobe_i,
  output lsu_pkg::word_t   rdata_o
);

  import lsu_pkg::*;

  word_t mem [MemWords];

  // Byte lanes are written one by one under their strobe bit
  always_ff @(posedge clk_core) begin
    if (en_i && we_i) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (strobe_i[lane]) begin
          mem[index_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
        end
      end
    end
  end

  // Read port returns the word as it was before any write in the same cycle
  // Output holds when the RAM is idle
  always_ff @(posedge clk_core) begin
    if (en_i) begin
      rdata_o <= mem[index_i];
    end
  end

endmodule

// File: hdl/lsu_request.sv
module lsu_request (
  input  logic                 request_valid_i,
  input  lsu_pkg::read_write_t transaction_i,
  output logic                 ram_en_o,
  output logic                 io_en_o,
  output logic                 we_o,
  output lsu_pkg::index_t      index_o,
  output lsu_pkg::word_t       wdata_o,
  output lsu_pkg::strobe_t     strobe_o
);

  import lsu_pkg::*;

  logic  access;
  logic  is_store;
  word_t target_base;
  word_t offset;

  // A misaligned instruction still travels down the pipe, but only to
  // raise its trap, so it must never reach a target
  assign access = request_valid_i & ~transaction_i.misaligned_address;

  assign is_store = transaction_i.mem_data.op == MEM_OP_STORE;

  // Only one requester exists, so the address alone picks the target
  assign ram_en_o = access & transaction_i.is_memory;
  assign io_en_o = access & ~transaction_i.is_memory;

  assign we_o = access & is_store;

  always_comb begin
    // Anything outside the RAM window is treated as I/O
    if (transaction_i.is_memory) begin
      target_base = MemBase;
    end else begin
      target_base = IoBase;
    end

    offset = transaction_i.address - target_base;

    // Drop the byte offset to get a word index within the target
    index_o = offset[ByteOffsetBits +: IndexBits];
  end

  // Write data goes out unconditionally, the strobe is what qualifies it
  assign wdata_o = transaction_i.write_data;

  always_comb begin
    if (we_o) begin
      strobe_o = transaction_i.write_strobe;
    end else begin
      strobe_o = '0;
    end
  end

endmodule

// File: hdl/lsu_address.sv
module lsu_address (
  input  logic                clk_core,
  input  logic                reset_i,
  input  logic                flush_i,
  input  logic                request_stall_i,
  input  logic                response_stall_i,
  input  lsu_pkg::mem_data_t  op_i,
  input  logic                valid_i,
  output lsu_pkg::read_write_t transaction_o,
  output logic                request_valid_o,
  output logic                response_valid_o
);

  import lsu_pkg::*;

  word_t       address;
  word_t       write_data;
  strobe_t     write_strobe;
  logic        misaligned;
  read_write_t next_transaction;
  logic        request_valid_q;
  logic        accept;

  // The base always comes from rs1, for loads and stores alike
  assign address = op_i.rs1 + op_i.immediate;

  // Both sides must be free for a new instruction to enter
  assign accept = ~request_stall_i & ~response_stall_i;

  always_comb begin
    // Every access goes out as a full word, so narrow store data is
    // replicated across the word and the strobe marks the live bytes
    write_data = op_i.rs2;
    write_strobe = 4'b1111;
    misaligned = 1'b0;

    case (op_i.size)
      MEM_SIZE_WORD: begin
        // Words need both low address bits clear
        misaligned = address[ByteOffsetBits-1:0] != '0;
      end

      MEM_SIZE_HALF: begin
        write_data = {2{op_i.rs2[15:0]}};
        // Address bit 1 picks the upper or the lower half
        if (address[1]) begin
          write_strobe = 4'b1100;
        end else begin
          write_strobe = 4'b0011;
        end
        misaligned = address[0];
      end

      MEM_SIZE_BYTE: begin
        write_data = {4{op_i.rs2[7:0]}};
        // One strobe bit, walked up by the byte offset
        write_strobe = strobe_t'(4'b0001 << address[ByteOffsetBits-1:0]);
      end

      default: begin
        // Unused size encoding behaves as a word access
        misaligned = address[ByteOffsetBits-1:0] != '0;
      end
    endcase

    next_transaction.address = address;
    next_transaction.mem_data = op_i;
    next_transaction.is_memory = address_is_memory(address);
    next_transaction.write_data = write_data;
    next_transaction.write_strobe = write_strobe;
    next_transaction.misaligned_address = misaligned;
  end

  // Each valid only moves when its own side is not stalled, and it only
  // picks up a new instruction when the other side is free as well
  always_ff @(posedge clk_core) begin
    if (reset_i || flush_i) begin
      request_valid_q <= 1'b0;
      response_valid_o <= 1'b0;
    end else begin
      if (!request_stall_i) begin
        request_valid_q <= valid_i & ~response_stall_i;
      end
      if (!response_stall_i) begin
        response_valid_o <= valid_i & ~request_stall_i;
      end
    end
  end

  // Transaction payload, loaded only on an accepted instruction
  always_ff @(posedge clk_core) begin
    if (accept) begin
      transaction_o <= next_transaction;
    end
  end

  // A flush in the cycle of the target access has to cancel that access,
  // otherwise a store already on its way would still land in memory
  assign request_valid_o = request_valid_q & ~flush_i;

endmodule

// File: hdl/lsu_pkg.sv
package lsu_pkg;

  // Data and address words are both 32 bits wide on this core
  typedef logic [31:0] word_t;
  typedef logic [3:0] strobe_t;
  typedef logic [4:0] reg_index_t;

  // Number of address bits that select a byte within a word
  localparam int ByteOffsetBits = 2;

  // Data RAM region, word organized
  localparam word_t MemBase = 32'h0000_1000;
  localparam int MemWords = 256;
  localparam word_t MemLimit = MemBase + word_t'(MemWords * 4);

  // Width of the word index that the request stage hands to either target
  localparam int IndexBits = $clog2(MemWords);
  typedef logic [IndexBits-1:0] index_t;

  // I/O region with four scratch registers selected by address bits 3 to 2
  localparam word_t IoBase = 32'h0000_2000;
  localparam int IoRegs = 4;
  localparam int IoSelBits = $clog2(IoRegs);

  typedef enum logic [1:0] {
    MEM_OP_LOAD,
    MEM_OP_LOAD_UNSIGNED,
    MEM_OP_STORE
  } mem_op_e;

  typedef enum logic [1:0] {
    MEM_SIZE_BYTE,
    MEM_SIZE_HALF,
    MEM_SIZE_WORD
  } mem_size_e;

  // One memory instruction as it leaves decode
  typedef struct packed {
    mem_op_e    op;
    mem_size_e  size;
    word_t      rs1;
    word_t      rs2;
    word_t      immediate;
    reg_index_t rd;
  } mem_data_t;

  // Registered transaction shared by the request and response sides
  typedef struct packed {
    word_t     address;
    mem_data_t mem_data;
    logic      is_memory;
    word_t     write_data;
    strobe_t   write_strobe;
    logic      misaligned_address;
  } read_write_t;

  typedef struct packed {
    reg_index_t rd;
    word_t      rd_value;
    logic       is_load;
    logic       trap;
    word_t      trap_address;
  } lsu_result_t;

  // True when the address falls inside the data RAM window
  function automatic logic address_is_memory(word_t address);
    return (address >= MemBase) && (address < MemLimit);
  endfunction

endpackage
